// File: include/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// the CPU presents a byte address of this many bits
`define CACHE_ADDR_W 16

// each set holds one even and one odd way, so the data array has twice this many lines
`define CACHE_SETS 64

// a line is this many 16-bit words, which gives a 16-byte line
`define CACHE_WORDS 8

// cycles from a memory read strobe until the word is on memData
// any value of one or more works, since the fill timer sizes its counter from it
`define CACHE_MEM_LAT 4

`endif

// File: source/cache_pkg.sv
`default_nettype none

package cache_pkg;

   // the CPU byte address split into its cache fields
   // byteSel is carried along but ignored, since only word reads exist
   typedef struct packed {
      logic [5:0] tag;
      logic [5:0] set;
      logic [2:0] wordIdx;
      logic       byteSel;
   } cacheAddr_t;

   // one metadata entry per way per set
   // only the even way's lru bit means anything and it names the next victim
   typedef struct packed {
      logic       lru;
      logic       valid;
      logic [5:0] tag;
   } metaEntry_t;

   // steers a single word write into the data array while a line is filled
   typedef struct packed {
      logic       write;
      logic       way;
      logic [2:0] wordIdx;
   } fillCtl_t;

   // states of the lookup and fill sequencer
   typedef enum logic [2:0] {
      FILL_IDLE,
      FILL_LOOKUP,
      FILL_REQ,
      FILL_WAIT,
      FILL_TAG,
      FILL_DONE
   } fillState_t;

endpackage

`default_nettype wire

// File: source/metaDataArray.sv
`default_nettype none

`include "cache_cfg.svh"

module metaDataArray (
   input  wire                     clk,
   input  wire                     rstN,
   input  wire cache_pkg::cacheAddr_t lookupAddr,
   input  wire                     tagWrite,
   input  wire                     touch,
   input  wire                     touchWay,
   output logic                    hit,
   output logic                    hitWay,
   output logic                    victimWay
);

   // even and odd way entries live in separate arrays indexed by set
   cache_pkg::metaEntry_t evenWay [`CACHE_SETS];
   cache_pkg::metaEntry_t oddWay  [`CACHE_SETS];

   cache_pkg::metaEntry_t evenEntry;
   cache_pkg::metaEntry_t oddEntry;
   cache_pkg::metaEntry_t evenNext;
   cache_pkg::metaEntry_t oddNext;

   logic hitEven;
   logic hitOdd;

   // the metadata read is combinational so the compare lands in the lookup cycle
   assign evenEntry = evenWay[lookupAddr.set];
   assign oddEntry  = oddWay[lookupAddr.set];

   // a way hits only when it holds a valid line with a matching tag
   assign hitEven = evenEntry.valid && (evenEntry.tag == lookupAddr.tag);
   assign hitOdd  = oddEntry.valid && (oddEntry.tag == lookupAddr.tag);

   assign hit    = hitEven || hitOdd;
   assign hitWay = hitOdd;

   // lru of zero evicts the even way and lru of one evicts the odd way
   assign victimWay = evenEntry.lru;

   // build the updated entries for the current set
   always_comb begin
      evenNext = evenEntry;
      oddNext  = oddEntry;
      if (tagWrite && !victimWay) begin
         evenNext.valid = 1'b1;
         evenNext.tag   = lookupAddr.tag;
      end
      if (tagWrite && victimWay) begin
         oddNext.valid = 1'b1;
         oddNext.tag   = lookupAddr.tag;
      end
      // the way just used becomes most recent, so the other one is the next victim
      if (touch) begin
         evenNext.lru = ~touchWay;
      end
   end

   // reset leaves every line invalid and every lru bit pointing at the even way
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < `CACHE_SETS; i++) begin
            evenWay[i] <= '0;
            oddWay[i]  <= '0;
         end
      end else begin
         // the even entry carries the lru bit so it is written on a touch as well
         if (touch || (tagWrite && !victimWay)) begin
            evenWay[lookupAddr.set] <= evenNext;
         end
         if (tagWrite && victimWay) begin
            oddWay[lookupAddr.set] <= oddNext;
         end
      end
   end

   // a fill always replaces the victim, so a tag can never be resident in both ways
   assert property (@(posedge clk) disable iff (!rstN) !(hitEven && hitOdd))
      else $error("metaDataArray both ways hit in set %0d", lookupAddr.set);

endmodule

`default_nettype wire

// File: source/dataArray.sv
`default_nettype none

`include "cache_cfg.svh"

module dataArray (
   input  wire                        clk,
   input  wire                        rstN,
   input  wire cache_pkg::cacheAddr_t lookupAddr,
   input  wire                        hitWay,
   input  wire cache_pkg::fillCtl_t   fillCtl,
   input  wire [15:0]                 fillData,
   output logic [15:0]                rdData
);

   // each set owns two adjacent lines, the even way first
   localparam int Lines = 2 * `CACHE_SETS;

   logic [15:0] lineStore [Lines][`CACHE_WORDS];

   logic [6:0] rdLine;
   logic [6:0] wrLine;

   // line index is twice the set plus the way
   assign rdLine = {lookupAddr.set, hitWay};
   assign wrLine = {lookupAddr.set, fillCtl.way};

   // a fill writes one word of the victim line per strobe
   always_ff @(posedge clk) begin
      if (fillCtl.write) begin
         lineStore[wrLine][fillCtl.wordIdx] <= fillData;
      end
   end

   // the read word is registered so it appears in the cycle after the lookup
   // while the request address stays put the output keeps the same word
   always_ff @(posedge clk) begin
      if (!rstN) begin
         rdData <= '0;
      end else begin
         rdData <= lineStore[rdLine][lookupAddr.wordIdx];
      end
   end

endmodule

`default_nettype wire

// File: source/fillTimer.sv
`default_nettype none

`include "cache_cfg.svh"

module fillTimer (
   input  wire        clk,
   input  wire        rstN,
   input  wire        start,
   input  wire        step,
   output logic       wordReady,
   output logic [2:0] wordIdx,
   output logic       lastWord
);

   // the counter has to hold the latency minus one
   localparam int CntW = $clog2(`CACHE_MEM_LAT + 1);

   logic [CntW-1:0] count;
   logic            busy;

   // the word is due when the count reaches zero with a read outstanding
   assign wordReady = busy && (count == '0);
   assign lastWord  = (wordIdx == 3'(`CACHE_WORDS - 1));

   always_ff @(posedge clk) begin
      if (!rstN) begin
         busy    <= 1'b0;
         count   <= '0;
         wordIdx <= '0;
      end else if (start) begin
         // a new line always begins with word zero
         busy    <= 1'b0;
         count   <= '0;
         wordIdx <= '0;
      end else if (step) begin
         // loading latency minus one puts wordReady exactly latency cycles after the strobe
         busy  <= 1'b1;
         count <= CntW'(`CACHE_MEM_LAT - 1);
      end else if (wordReady) begin
         busy    <= 1'b0;
         wordIdx <= wordIdx + 3'd1;
      end else if (busy) begin
         count <= count - 1'b1;
      end
   end

   // the sequencer only strobes again after the previous word has come back
   assert property (@(posedge clk) disable iff (!rstN) step |-> !busy)
      else $error("fillTimer step while word %0d is still pending", wordIdx);

endmodule

`default_nettype wire

// File: source/cacheFillFsm.sv
`default_nettype none

`include "cache_cfg.svh"

module cacheFillFsm (
   input  wire                         clk,
   input  wire                         rstN,
   input  wire                         rdReq,
   input  wire [`CACHE_ADDR_W-1:0]     addr,
   input  wire                         memGrant,
   input  wire                         hit,
   input  wire                         hitWay,
   input  wire                         victimWay,
   input  wire                         wordReady,
   input  wire [2:0]                   wordIdx,
   input  wire                         lastWord,
   output cache_pkg::cacheAddr_t       lookupAddr,
   output cache_pkg::fillCtl_t         fillCtl,
   output logic                        tagWrite,
   output logic                        touch,
   output logic                        touchWay,
   output logic                        timerStart,
   output logic                        timerStep,
   output logic                        memRdStrobe,
   output logic [`CACHE_ADDR_W-2:0]    memRdAddr,
   output logic                        rdDone,
   output logic                        missBusy
);

   cache_pkg::fillState_t state;
   cache_pkg::fillState_t stateNext;

   // the request address is captured once and drives every lookup of the request
   cache_pkg::cacheAddr_t reqAddr;
   logic                  victimQ;

   assign lookupAddr = reqAddr;

   // word address into backing memory is the line address plus the word being fetched
   assign memRdAddr = {reqAddr.tag, reqAddr.set, wordIdx};

   // the completion pulse is the single cycle spent in FILL_DONE
   assign rdDone = (state == cache_pkg::FILL_DONE);

   always_comb begin
      stateNext       = state;
      touch           = 1'b0;
      touchWay        = hitWay;
      tagWrite        = 1'b0;
      timerStart      = 1'b0;
      timerStep       = 1'b0;
      memRdStrobe     = 1'b0;
      fillCtl.write   = 1'b0;
      fillCtl.way     = victimQ;
      fillCtl.wordIdx = wordIdx;
      case (state)
         cache_pkg::FILL_IDLE: begin
            if (rdReq) begin
               stateNext = cache_pkg::FILL_LOOKUP;
            end
         end
         cache_pkg::FILL_LOOKUP: begin
            if (hit) begin
               // the read word is registered at the end of this cycle
               touch     = 1'b1;
               stateNext = cache_pkg::FILL_DONE;
            end else begin
               timerStart = 1'b1;
               stateNext  = cache_pkg::FILL_REQ;
            end
         end
         cache_pkg::FILL_REQ: begin
            // without a grant the fill simply waits here
            if (memGrant) begin
               memRdStrobe = 1'b1;
               timerStep   = 1'b1;
               stateNext   = cache_pkg::FILL_WAIT;
            end
         end
         cache_pkg::FILL_WAIT: begin
            if (wordReady) begin
               fillCtl.write = 1'b1;
               stateNext     = lastWord ? cache_pkg::FILL_TAG : cache_pkg::FILL_REQ;
            end
         end
         cache_pkg::FILL_TAG: begin
            // once the tag is in the line is resident and the lookup is repeated as a hit
            tagWrite  = 1'b1;
            stateNext = cache_pkg::FILL_LOOKUP;
         end
         cache_pkg::FILL_DONE: begin
            stateNext = cache_pkg::FILL_IDLE;
         end
         default: begin
            stateNext = cache_pkg::FILL_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state    <= cache_pkg::FILL_IDLE;
         reqAddr  <= '0;
         missBusy <= 1'b0;
      end else begin
         state <= stateNext;
         if ((state == cache_pkg::FILL_IDLE) && rdReq) begin
            reqAddr <= cache_pkg::cacheAddr_t'(addr);
         end
         // missBusy covers the whole fill and drops after the completion cycle
         if ((state == cache_pkg::FILL_LOOKUP) && !hit) begin
            missBusy <= 1'b1;
         end else if (state == cache_pkg::FILL_DONE) begin
            missBusy <= 1'b0;
         end
      end
   end

   // the victim is frozen at miss time so every word of the fill lands in the same way
   always_ff @(posedge clk) begin
      if ((state == cache_pkg::FILL_LOOKUP) && !hit) begin
         victimQ <= victimWay;
      end
   end

   // the completion pulse answers a request the CPU still holds at the captured address
   assert property (@(posedge clk) disable iff (!rstN) rdDone |-> rdReq && (addr == reqAddr))
      else $error("cacheFillFsm rdDone without a held request at the captured address");

endmodule

`default_nettype wire

// File: source/mainMemory.sv
`default_nettype none

`include "cache_cfg.svh"

module mainMemory (
   input  wire                      clk,
   input  wire                      rstN,
   input  wire                      loadEn,
   input  wire [`CACHE_ADDR_W-2:0]  loadAddr,
   input  wire [15:0]               loadData,
   input  wire                      rdStrobe,
   input  wire [`CACHE_ADDR_W-2:0]  rdAddr,
   input  wire                      wordReady,
   output logic [15:0]              memData
);

   // one 16-bit word for every even byte address
   localparam int Depth = 2 ** (`CACHE_ADDR_W - 1);

   logic [15:0]              wordStore [Depth];
   logic [`CACHE_ADDR_W-2:0] rdAddrQ;
   logic                     rdPending;

   // the load port writes in the cycle it is sampled
   always_ff @(posedge clk) begin
      if (loadEn) begin
         wordStore[loadAddr] <= loadData;
      end
   end

   // the address is held from the strobe until the word is handed over
   always_ff @(posedge clk) begin
      if (rdStrobe) begin
         rdAddrQ <= rdAddr;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         rdPending <= 1'b0;
      end else if (rdStrobe) begin
         rdPending <= 1'b1;
      end else if (wordReady) begin
         rdPending <= 1'b0;
      end
   end

   // the word is only driven in the cycle the fill timer marks as ready
   assign memData = wordReady ? wordStore[rdAddrQ] : '0;

   // the timer's ready pulse must always belong to a strobe this memory has seen
   assert property (@(posedge clk) disable iff (!rstN) wordReady |-> rdPending)
      else $error("mainMemory wordReady without an outstanding read");

endmodule

`default_nettype wire

// File: source/cacheTop.sv
`default_nettype none

`include "cache_cfg.svh"

module cacheTop (
   input  wire                      clk,
   input  wire                      rstN,
   input  wire                      rdReq,
   input  wire [`CACHE_ADDR_W-1:0]  addr,
   output logic [15:0]              rdData,
   output logic                     rdDone,
   output logic                     missBusy,
   input  wire                      memGrant,
   input  wire                      loadEn,
   input  wire [`CACHE_ADDR_W-2:0]  loadAddr,
   input  wire [15:0]               loadData
);

   cache_pkg::cacheAddr_t    lookupAddr;
   cache_pkg::fillCtl_t      fillCtl;
   logic                     hit;
   logic                     hitWay;
   logic                     victimWay;
   logic                     tagWrite;
   logic                     touch;
   logic                     touchWay;
   logic                     timerStart;
   logic                     timerStep;
   logic                     wordReady;
   logic [2:0]               wordIdx;
   logic                     lastWord;
   logic                     memRdStrobe;
   logic [`CACHE_ADDR_W-2:0] memRdAddr;
   logic [15:0]              memData;

   // the sequencer owns the lookup address and every write strobe
   cacheFillFsm i_fsm (
      .clk, .rstN, .rdReq, .addr, .memGrant, .hit, .hitWay, .victimWay,
      .wordReady, .wordIdx, .lastWord, .lookupAddr, .fillCtl, .tagWrite,
      .touch, .touchWay, .timerStart, .timerStep, .memRdStrobe, .memRdAddr,
      .rdDone, .missBusy
   );

   fillTimer i_timer (
      .clk, .rstN, .start(timerStart), .step(timerStep), .wordReady, .wordIdx, .lastWord
   );

   metaDataArray i_meta (
      .clk, .rstN, .lookupAddr, .tagWrite, .touch, .touchWay, .hit, .hitWay, .victimWay
   );

   // fill words go straight from the memory output into the victim line
   dataArray i_data (
      .clk, .rstN, .lookupAddr, .hitWay, .fillCtl, .fillData(memData), .rdData
   );

   mainMemory i_mem (
      .clk, .rstN, .loadEn, .loadAddr, .loadData, .rdStrobe(memRdStrobe),
      .rdAddr(memRdAddr), .wordReady, .memData
   );

endmodule

`default_nettype wire

// File: sim/cacheRefModel.sv
`default_nettype none

`include "cache_cfg.svh"

module cacheRefModel (
   input  wire                     clk,
   input  wire                     rstN,
   input  wire                     rdReq,
   input  wire [`CACHE_ADDR_W-1:0] addr,
   input  wire [15:0]              rdData,
   input  wire                     rdDone,
   input  wire                     missBusy,
   input  wire                     loadEn,
   input  wire [`CACHE_ADDR_W-2:0] loadAddr,
   input  wire [15:0]              loadData,
   input  wire [8*24-1:0]          testName,
   output int                      errCount
);
   timeunit 1ns;
   timeprecision 100ps;

   // mirror of backing memory plus the tags and LRU bit of every set
   logic [15:0]           memMirror [2 ** (`CACHE_ADDR_W - 1)];
   logic [5:0]            tagOf [2][`CACHE_SETS];
   logic                  validOf [2][`CACHE_SETS];
   logic                  lruOf [`CACHE_SETS];
   cache_pkg::cacheAddr_t req;
   logic                  hitEven;
   logic                  hitOdd;
   logic                  active;
   logic                  expMiss;
   logic [15:0]           expData;
   int                    cycles;

   assign req     = cache_pkg::cacheAddr_t'(addr);
   assign hitEven = validOf[0][req.set] && (tagOf[0][req.set] == req.tag);
   assign hitOdd  = validOf[1][req.set] && (tagOf[1][req.set] == req.tag);

   initial errCount = 0;

   task automatic reportError(input string msg);
      errCount++;
      $display("%s", msg);
   endtask

   always_ff @(posedge clk) begin
      if (loadEn) begin
         memMirror[loadAddr] <= loadData;
      end
      // reset empties every set but leaves memory alone
      if (!rstN) begin
         active <= 1'b0;
         cycles <= 0;
         for (int s = 0; s < `CACHE_SETS; s++) begin
            validOf[0][s] <= 1'b0;
            validOf[1][s] <= 1'b0;
            lruOf[s]      <= 1'b0;
         end
      end else if (active) begin
         cycles <= cycles + 1;
         active <= !rdDone;
      end else if (rdReq) begin
         // the prediction is taken in the cycle the DUT samples the request
         active  <= 1'b1;
         cycles  <= 1;
         expData <= memMirror[addr[`CACHE_ADDR_W-1:1]];
         expMiss <= !(hitEven || hitOdd);
         if (hitEven || hitOdd) begin
            lruOf[req.set] <= !hitOdd;
         end else begin
            // a miss fills the LRU way, which then becomes the most recent one
            tagOf[lruOf[req.set]][req.set]   <= req.tag;
            validOf[lruOf[req.set]][req.set] <= 1'b1;
            lruOf[req.set]                   <= !lruOf[req.set];
         end
      end
   end

   assert property (@(posedge clk) disable iff (!rstN) rdDone |-> rdData == expData)
      else reportError($sformatf("** Error [%0s] rdData expected %h actual %h",
         testName, $sampled(expData), $sampled(rdData)));
   assert property (@(posedge clk) disable iff (!rstN) rdDone |-> missBusy == expMiss)
      else reportError($sformatf("** Error [%0s] missBusy expected %0b actual %0b",
         testName, $sampled(expMiss), $sampled(missBusy)));
   assert property (@(posedge clk) disable iff (!rstN) rdDone && !expMiss |-> cycles == 2)
      else reportError($sformatf("** Error [%0s] hit latency expected 2 actual %0d",
         testName, $sampled(cycles)));
   // a line cannot arrive faster than one memory latency per word
   assert property (@(posedge clk) disable iff (!rstN)
      rdDone && expMiss |-> cycles > `CACHE_WORDS * `CACHE_MEM_LAT)
      else reportError($sformatf("[%0s] read completed after %0d cycles, before its fill",
         testName, $sampled(cycles)));
   assert property (@(posedge clk) disable iff (!rstN) !(active && expMiss) |-> !missBusy)
      else reportError($sformatf("[%0s] missBusy went high outside a miss", testName));
   assert property (@(posedge clk) !rstN |=> !rdDone && !missBusy)
      else reportError($sformatf("[%0s] rdDone or missBusy high right after reset", testName));

endmodule

`default_nettype wire

// File: sim/cacheTb.sv
`default_nettype none

`include "cache_cfg.svh"

module cacheTb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int ClkPeriod = 4;
   localparam int MemWords  = 2 ** (`CACHE_ADDR_W - 1);
   // one full fill per read, doubled for grant stalls, for up to 40 reads plus the load
   localparam int FillCycles = 2 * `CACHE_WORDS * (`CACHE_MEM_LAT + 1) + 8;
   localparam int WatchdogNs = 4 * ClkPeriod * (MemWords + 40 * FillCycles + 40);
   // A, B, A, C, A, B in one set, so C evicts B
   localparam logic [5:0] LruTags [6] = '{6'h03, 6'h11, 6'h03, 6'h32, 6'h03, 6'h11};

   logic                  clk = 1'b0;
   logic                  rstN;
   logic                  rdReq;
   logic                  memGrant;
   logic                  loadEn;
   logic                  rdDone;
   logic                  missBusy;
   logic                  randomGrant;
   logic [15:0]           addr;
   logic [15:0]           rdData;
   logic [15:0]           loadData;
   logic [14:0]           loadAddr;
   logic [8*24-1:0]       testName;
   cache_pkg::cacheAddr_t resident;
   int                    errCount;
   int                    errBefore;
   int                    testsRun;
   int                    testsBad;

   always #(ClkPeriod / 2) clk = ~clk;

   cacheTop i_dut (
      .clk, .rstN, .rdReq, .addr, .rdData, .rdDone, .missBusy, .memGrant,
      .loadEn, .loadAddr, .loadData
   );

   cacheRefModel i_model (
      .clk, .rstN, .rdReq, .addr, .rdData, .rdDone, .missBusy, .loadEn,
      .loadAddr, .loadData, .testName, .errCount
   );

   function automatic logic [15:0] makeAddr(input logic [5:0] tag, input logic [5:0] set,
                                            input logic [2:0] word);
      return {tag, set, word, 1'b0};
   endfunction

   task automatic applyReset();
      @(posedge clk);
      rstN <= 1'b0;
      repeat (5) @(posedge clk);
      rstN <= 1'b1;
   endtask

   // holds the request until rdDone, with a random grant when test 5 asks for it
   task automatic readWord(input logic [15:0] a);
      @(posedge clk);
      rdReq <= 1'b1;
      addr  <= a;
      do begin
         @(posedge clk);
         if (randomGrant) begin
            memGrant <= 1'($urandom_range(1, 0));
         end
      end while (!rdDone);
      rdReq    <= 1'b0;
      memGrant <= 1'b1;
   endtask

   task automatic beginTest(input logic [8*24-1:0] name);
      testName  = name;
      errBefore = errCount;
   endtask

   // one more edge lets the model's checks on the last rdDone land first
   task automatic endTest();
      @(posedge clk);
      testsRun++;
      if (errCount == errBefore) begin
         $display("[%0d] %0s: ok", testsRun, testName);
      end else begin
         testsBad++;
         $display("[%0d] %0s: %0d errors", testsRun, testName, errCount - errBefore);
      end
   endtask

   initial begin
      rstN        <= 1'b0;
      rdReq       <= 1'b0;
      addr        <= '0;
      memGrant    <= 1'b1;
      loadEn      <= 1'b0;
      loadAddr    <= '0;
      loadData    <= '0;
      randomGrant = 1'b0;
      testsRun    = 0;
      testsBad    = 0;
      testName    = "load";
      void'($urandom(32'hfa8d_b152));
      applyReset();
      // every word of backing memory gets a random value before the first read
      for (int i = 0; i < MemWords; i++) begin
         @(posedge clk);
         loadEn   <= 1'b1;
         loadAddr <= 15'(i);
         loadData <= 16'($urandom);
      end
      @(posedge clk);
      loadEn <= 1'b0;
      resident = makeAddr(6'($urandom), 6'd0, 3'($urandom));
      beginTest("miss after reset");
      readWord(resident);
      for (int s = 1; s < 4; s++) begin
         readWord(makeAddr(6'($urandom), 6'(s), 3'($urandom)));
      end
      endTest();
      beginTest("hit on same line");
      for (int w = 0; w < `CACHE_WORDS; w++) begin
         readWord(makeAddr(resident.tag, resident.set, 3'(w)));
      end
      endTest();
      // only the first touch of each tag misses
      beginTest("two ways resident");
      for (int i = 0; i < 8; i++) begin
         readWord(makeAddr((i % 2 == 1) ? 6'h2a : 6'h05, 6'd10, 3'($urandom)));
      end
      endTest();
      beginTest("LRU eviction");
      for (int i = 0; i < 6; i++) begin
         readWord(makeAddr(LruTags[i], 6'd20, 3'($urandom)));
      end
      endTest();
      beginTest("random grant");
      randomGrant = 1'b1;
      for (int s = 30; s < 34; s++) begin
         readWord(makeAddr(6'($urandom), 6'(s), 3'($urandom)));
      end
      randomGrant = 1'b0;
      endTest();
      // the resident line is gone after reset, so it misses and then hits
      beginTest("second reset");
      applyReset();
      readWord(resident);
      readWord(resident);
      endTest();
      $display("%0d tests run, %0d with errors, %0d errors in all", testsRun, testsBad, errCount);
      if (testsBad == 0 && errCount == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   initial begin
      #(WatchdogNs);
      $display("watchdog expired after %0d ns, a read never completed", WatchdogNs);
      $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
source/cache_pkg.sv
source/metaDataArray.sv
source/dataArray.sv
source/fillTimer.sv
source/cacheFillFsm.sv
source/mainMemory.sv
source/cacheTop.sv
sim/cacheRefModel.sv
sim/cacheTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the cache testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module cacheTb -o cacheSim &&
./obj_dir/cacheSim | tee /dev/stderr | grep -x "test passed" > /dev/null &&
echo "simulation PASSED" ||
{ echo "simulation FAILED"; exit 1; }
